//--- design/dbg_pkg.sv
package dbg_pkg;

   // Flit and header geometry
   localparam int FLIT_CONTENT_W = 16;
   localparam int DEST_W         = 5;
   localparam int CLASS_W        = 3;
   localparam int SRC_W          = 8;

   // Debug addresses on the dispatch level
   localparam logic [DEST_W-1:0] ADDR_EXT = 5'd0;
   localparam logic [DEST_W-1:0] ADDR_TCM = 5'd1;
   localparam logic [DEST_W-1:0] ADDR_ITM = 5'd2;

   // Packet classes
   localparam logic [CLASS_W-1:0] CLASS_REG    = 3'd0;
   localparam logic [CLASS_W-1:0] CLASS_TRACE  = 3'd1;
   localparam logic [CLASS_W-1:0] CLASS_CONFIG = 3'd2;

   // Register map of the trace control module
   // Address word holds a write bit above the register address
   localparam int REG_WRITE_BIT = 15;
   localparam logic [REG_WRITE_BIT-1:0] REG_SYSTEM_ID    = 15'd0;
   localparam logic [REG_WRITE_BIT-1:0] REG_MODULE_COUNT = 15'd1;
   localparam logic [REG_WRITE_BIT-1:0] REG_CPU_CTRL     = 15'd2;

   localparam logic [FLIT_CONTENT_W-1:0] SYSTEM_ID    = 16'h0C5A;
   localparam logic [FLIT_CONTENT_W-1:0] MODULE_COUNT = 16'd2;

   // CPU control word
   localparam int CPU_CTRL_STALL_BIT = 0;
   localparam int CPU_CTRL_RESET_BIT = 1;
   localparam int CPU_CTRL_START_BIT = 2;

   // Trace sizes
   localparam int TS_W             = 16;
   localparam int PC_W             = 32;
   localparam int TRACE_FIFO_DEPTH = 4;

   // Flit types
   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,
      FLIT_HEADER  = 2'b01,
      FLIT_LAST    = 2'b10,
      FLIT_SINGLE  = 2'b11
   } flit_type_e;

   typedef struct packed {
      logic [DEST_W-1:0]  dest;
      logic [CLASS_W-1:0] pkt_class;
      logic [SRC_W-1:0]   src;
   } dbg_header_t;

   // Header flits carry a header and all others a plain data word
   typedef union packed {
      dbg_header_t               header;
      logic [FLIT_CONTENT_W-1:0] data;
   } dbg_content_u;

   typedef struct packed {
      flit_type_e   ftype;
      dbg_content_u content;
   } dbg_flit_t;

   // CPU retire port
   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] pc;
   } trace_evt_t;

endpackage

//--- design/dbg_in_router.sv
`timescale 1ns/1ps

module dbg_in_router (
   input  logic              clk,
   input  logic              rst_n,
   input  dbg_pkg::dbg_flit_t in_flit,
   input  logic              in_valid,
   output logic              in_ready,
   output dbg_pkg::dbg_flit_t tcm_flit,
   output logic              tcm_valid,
   input  logic              tcm_ready,
   output dbg_pkg::dbg_flit_t itm_flit,
   output logic              itm_valid,
   input  logic              itm_ready
);

   typedef enum logic [1:0] {
      TGT_DROP,
      TGT_TCM,
      TGT_ITM
   } tgt_e;

   tgt_e cur_tgt;
   tgt_e head_tgt;
   tgt_e tgt;
   logic is_head;

   assign is_head = (in_flit.ftype == dbg_pkg::FLIT_HEADER) ||
                    (in_flit.ftype == dbg_pkg::FLIT_SINGLE);

   // Target from the header view of the content word
   always_comb begin
      if (in_flit.content.header.dest == dbg_pkg::ADDR_TCM)
         head_tgt = TGT_TCM;
      else if (in_flit.content.header.dest == dbg_pkg::ADDR_ITM)
         head_tgt = TGT_ITM;
      else
         head_tgt = TGT_DROP;
   end

   // Body flits follow the target of their header
   assign tgt = is_head ? head_tgt : cur_tgt;

   assign tcm_flit  = in_flit;
   assign itm_flit  = in_flit;
   assign tcm_valid = in_valid && (tgt == TGT_TCM);
   assign itm_valid = in_valid && (tgt == TGT_ITM);

   // Unknown destinations are swallowed
   always_comb begin
      case (tgt)
         TGT_TCM: in_ready = tcm_ready;
         TGT_ITM: in_ready = itm_ready;
         default: in_ready = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cur_tgt <= TGT_DROP;
      end else if (in_valid && in_ready && in_flit.ftype == dbg_pkg::FLIT_HEADER) begin
         cur_tgt <= head_tgt;
      end
   end

   a_one_target : assert property (@(posedge clk) disable iff (!rst_n)
      !(tcm_valid && itm_valid));

endmodule

//--- design/tcm.sv
`timescale 1ns/1ps

module tcm (
   input  logic              clk,
   input  logic              rst_n,
   input  dbg_pkg::dbg_flit_t req_flit,
   input  logic              req_valid,
   output logic              req_ready,
   output dbg_pkg::dbg_flit_t rsp_flit,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic              cpu_stall,
   output logic              cpu_reset,
   output logic              start_cpu
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_ADDR,
      S_DATA,
      S_RSP_HDR,
      S_RSP_DATA
   } state_e;

   state_e state;
   logic   req_fire;
   logic   wr_q;
   logic [dbg_pkg::REG_WRITE_BIT-1:0]  addr_q;
   logic [dbg_pkg::SRC_W-1:0]          src_q;
   logic [dbg_pkg::FLIT_CONTENT_W-1:0] rd_value;

   assign req_fire  = req_valid && req_ready;
   // No new request while a response is pending
   assign req_ready = (state == S_IDLE) || (state == S_ADDR) || (state == S_DATA);
   assign rsp_valid = (state == S_RSP_HDR) || (state == S_RSP_DATA);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         cpu_stall <= 1'b0;
         cpu_reset <= 1'b0;
         start_cpu <= 1'b0;
      end else begin
         start_cpu <= 1'b0;
         case (state)
            S_IDLE: begin
               if (req_fire && req_flit.ftype == dbg_pkg::FLIT_HEADER)
                  state <= S_ADDR;
            end
            S_ADDR: begin
               // A last flit here ends a read
               if (req_fire) begin
                  if (req_flit.ftype == dbg_pkg::FLIT_LAST)
                     state <= S_RSP_HDR;
                  else
                     state <= S_DATA;
               end
            end
            S_DATA: begin
               if (req_fire && req_flit.ftype == dbg_pkg::FLIT_LAST) begin
                  if (wr_q && addr_q == dbg_pkg::REG_CPU_CTRL) begin
                     cpu_stall <= req_flit.content.data[dbg_pkg::CPU_CTRL_STALL_BIT];
                     cpu_reset <= req_flit.content.data[dbg_pkg::CPU_CTRL_RESET_BIT];
                     start_cpu <= req_flit.content.data[dbg_pkg::CPU_CTRL_START_BIT];
                  end
                  state <= S_IDLE;
               end
            end
            S_RSP_HDR: begin
               if (rsp_ready)
                  state <= S_RSP_DATA;
            end
            S_RSP_DATA: begin
               if (rsp_ready)
                  state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Requester and address of the packet in flight
   always_ff @(posedge clk) begin
      if (req_fire && state == S_IDLE)
         src_q <= req_flit.content.header.src;
      if (req_fire && state == S_ADDR) begin
         addr_q <= req_flit.content.data[dbg_pkg::REG_WRITE_BIT-1:0];
         wr_q   <= req_flit.content.data[dbg_pkg::REG_WRITE_BIT];
      end
   end

   // Register read mux, unknown addresses read as zero
   always_comb begin
      rd_value = '0;
      case (addr_q)
         dbg_pkg::REG_SYSTEM_ID:    rd_value = dbg_pkg::SYSTEM_ID;
         dbg_pkg::REG_MODULE_COUNT: rd_value = dbg_pkg::MODULE_COUNT;
         dbg_pkg::REG_CPU_CTRL: begin
            rd_value[dbg_pkg::CPU_CTRL_STALL_BIT] = cpu_stall;
            rd_value[dbg_pkg::CPU_CTRL_RESET_BIT] = cpu_reset;
         end
         default: rd_value = '0;
      endcase
   end

   always_comb begin
      rsp_flit.ftype        = dbg_pkg::FLIT_LAST;
      rsp_flit.content.data = rd_value;
      if (state == S_RSP_HDR) begin
         rsp_flit.ftype                    = dbg_pkg::FLIT_HEADER;
         rsp_flit.content.header.dest      = src_q[dbg_pkg::DEST_W-1:0];
         rsp_flit.content.header.pkt_class = dbg_pkg::CLASS_REG;
         rsp_flit.content.header.src       = {{(dbg_pkg::SRC_W - dbg_pkg::DEST_W){1'b0}},
                                              dbg_pkg::ADDR_TCM};
      end
   end

   a_start_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      start_cpu |=> !start_cpu);

endmodule

//--- design/itm.sv
`timescale 1ns/1ps

module itm (
   input  logic               clk,
   input  logic               rst_n,
   input  dbg_pkg::dbg_flit_t  cfg_flit,
   input  logic               cfg_valid,
   output logic               cfg_ready,
   input  dbg_pkg::trace_evt_t trace,
   output dbg_pkg::dbg_flit_t  pkt_flit,
   output logic               pkt_valid,
   input  logic               pkt_ready,
   output logic               sys_clk_disable
);

   logic [dbg_pkg::TS_W-1:0] ts;
   logic                     trace_en;
   logic                     cfg_match;
   logic                     cfg_fire;

   // Event FIFO with one timestamp and one pc per entry
   logic [dbg_pkg::TS_W-1:0] fifo_ts [dbg_pkg::TRACE_FIFO_DEPTH];
   logic [dbg_pkg::PC_W-1:0] fifo_pc [dbg_pkg::TRACE_FIFO_DEPTH];
   logic [$clog2(dbg_pkg::TRACE_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(dbg_pkg::TRACE_FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(dbg_pkg::TRACE_FIFO_DEPTH):0]   count;
   logic full;
   logic empty;
   logic push;
   logic pop;

   // Position inside the four-flit trace packet
   logic [1:0] flit_idx;

   assign cfg_ready = 1'b1;
   assign cfg_fire  = cfg_valid && cfg_ready;

   // Only config class packets may change the enable bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         trace_en  <= 1'b0;
         cfg_match <= 1'b0;
      end else if (cfg_fire) begin
         if (cfg_flit.ftype == dbg_pkg::FLIT_HEADER)
            cfg_match <= (cfg_flit.content.header.pkt_class == dbg_pkg::CLASS_CONFIG);
         else if (cfg_flit.ftype == dbg_pkg::FLIT_LAST && cfg_match)
            trace_en <= cfg_flit.content.data[0];
      end
   end

   assign full  = (count == dbg_pkg::TRACE_FIFO_DEPTH);
   assign empty = (count == 0);

   // A full FIFO halts the system clock while the source holds its event
   assign sys_clk_disable = trace_en && full;
   assign push = trace.valid && trace_en && !full;
   assign pop  = pkt_valid && pkt_ready && (flit_idx == 2'd3);

   assign pkt_valid = !empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ts       <= '0;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         flit_idx <= '0;
      end else begin
         ts <= ts + 1'b1;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
         if (pkt_valid && pkt_ready)
            flit_idx <= flit_idx + 1'b1;
      end
   end

   // Event is stamped with the cycle it is accepted in
   always_ff @(posedge clk) begin
      if (push) begin
         fifo_ts[wr_ptr] <= ts;
         fifo_pc[wr_ptr] <= trace.pc;
      end
   end

   always_comb begin
      pkt_flit.ftype        = dbg_pkg::FLIT_PAYLOAD;
      pkt_flit.content.data = fifo_ts[rd_ptr];
      case (flit_idx)
         2'd0: begin
            pkt_flit.ftype                    = dbg_pkg::FLIT_HEADER;
            pkt_flit.content.header.dest      = dbg_pkg::ADDR_EXT;
            pkt_flit.content.header.pkt_class = dbg_pkg::CLASS_TRACE;
            pkt_flit.content.header.src       = {{(dbg_pkg::SRC_W - dbg_pkg::DEST_W){1'b0}},
                                                 dbg_pkg::ADDR_ITM};
         end
         2'd2: begin
            pkt_flit.content.data =
               fifo_pc[rd_ptr][dbg_pkg::PC_W-1 -: dbg_pkg::FLIT_CONTENT_W];
         end
         2'd3: begin
            pkt_flit.ftype        = dbg_pkg::FLIT_LAST;
            pkt_flit.content.data = fifo_pc[rd_ptr][dbg_pkg::FLIT_CONTENT_W-1:0];
         end
         default: ;
      endcase
   end

   // Pointers that meet must agree with the fill count
   a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (wr_ptr != rd_ptr) || empty);
   a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> (wr_ptr != rd_ptr) || full);

endmodule

//--- design/dbg_out_arbiter.sv
`timescale 1ns/1ps

module dbg_out_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  dbg_pkg::dbg_flit_t a_flit,
   input  logic              a_valid,
   output logic              a_ready,
   input  dbg_pkg::dbg_flit_t b_flit,
   input  logic              b_valid,
   output logic              b_ready,
   output dbg_pkg::dbg_flit_t out_flit,
   output logic              out_valid,
   input  logic              out_ready
);

   logic locked;
   logic lock_sel;
   logic prio;
   logic sel;
   logic last;

   // sel low picks a, high picks b
   always_comb begin
      if (locked)
         sel = lock_sel;
      else if (a_valid && b_valid)
         sel = prio;
      else
         sel = b_valid;
   end

   assign out_valid = sel ? b_valid : a_valid;
   assign out_flit  = sel ? b_flit : a_flit;
   assign a_ready   = out_ready && !sel;
   assign b_ready   = out_ready && sel;

   assign last = (out_flit.ftype == dbg_pkg::FLIT_LAST) ||
                 (out_flit.ftype == dbg_pkg::FLIT_SINGLE);

   // Grant holds from the first offered flit until the last one is taken
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         locked   <= 1'b0;
         lock_sel <= 1'b0;
         prio     <= 1'b0;
      end else if (out_valid) begin
         if (out_ready && last) begin
            locked <= 1'b0;
            prio   <= !sel;
         end else begin
            locked   <= 1'b1;
            lock_sel <= sel;
         end
      end
   end

   a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

//--- design/debug_system.sv
`timescale 1ns/1ps

module debug_system (
   input  logic               clk,
   input  logic               rst_n,
   input  dbg_pkg::dbg_flit_t  in_flit,
   input  logic               in_valid,
   output logic               in_ready,
   output dbg_pkg::dbg_flit_t  out_flit,
   output logic               out_valid,
   input  logic               out_ready,
   input  dbg_pkg::trace_evt_t trace,
   output logic               sys_clk_disable,
   output logic               cpu_stall,
   output logic               cpu_reset,
   output logic               start_cpu
);

   // Router to modules
   dbg_pkg::dbg_flit_t tcm_req_flit;
   logic               tcm_req_valid;
   logic               tcm_req_ready;
   dbg_pkg::dbg_flit_t itm_cfg_flit;
   logic               itm_cfg_valid;
   logic               itm_cfg_ready;

   // Modules to arbiter
   dbg_pkg::dbg_flit_t tcm_rsp_flit;
   logic               tcm_rsp_valid;
   logic               tcm_rsp_ready;
   dbg_pkg::dbg_flit_t itm_pkt_flit;
   logic               itm_pkt_valid;
   logic               itm_pkt_ready;

   dbg_in_router u_in_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .tcm_flit  (tcm_req_flit),
      .tcm_valid (tcm_req_valid),
      .tcm_ready (tcm_req_ready),
      .itm_flit  (itm_cfg_flit),
      .itm_valid (itm_cfg_valid),
      .itm_ready (itm_cfg_ready)
   );

   tcm u_tcm (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_flit  (tcm_req_flit),
      .req_valid (tcm_req_valid),
      .req_ready (tcm_req_ready),
      .rsp_flit  (tcm_rsp_flit),
      .rsp_valid (tcm_rsp_valid),
      .rsp_ready (tcm_rsp_ready),
      .cpu_stall (cpu_stall),
      .cpu_reset (cpu_reset),
      .start_cpu (start_cpu)
   );

   itm u_itm (
      .clk             (clk),
      .rst_n           (rst_n),
      .cfg_flit        (itm_cfg_flit),
      .cfg_valid       (itm_cfg_valid),
      .cfg_ready       (itm_cfg_ready),
      .trace           (trace),
      .pkt_flit        (itm_pkt_flit),
      .pkt_valid       (itm_pkt_valid),
      .pkt_ready       (itm_pkt_ready),
      .sys_clk_disable (sys_clk_disable)
   );

   dbg_out_arbiter u_out_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .a_flit    (tcm_rsp_flit),
      .a_valid   (tcm_rsp_valid),
      .a_ready   (tcm_rsp_ready),
      .b_flit    (itm_pkt_flit),
      .b_valid   (itm_pkt_valid),
      .b_ready   (itm_pkt_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

//--- testbench/tb_debug_system.sv
`timescale 1ns/1ps

module tb_debug_system;

   localparam int CLK_PERIOD = 100;

   typedef enum logic [2:0] {
      OP_READ,
      OP_WRITE,
      OP_CFG,
      OP_TRACE,
      OP_BURST,
      OP_DROP,
      OP_MIXED
   } op_e;

   // arg is a register address or an event count
   typedef struct packed {
      op_e         op;
      logic [15:0] arg;
      logic [15:0] data;
      logic [15:0] exp;
   } row_t;

   typedef struct packed {
      logic [15:0] ts;
      logic [31:0] pc;
   } trace_rec_t;

   typedef struct packed {
      logic [4:0]  dest;
      logic [7:0]  src;
      logic [15:0] value;
   } rsp_rec_t;

   logic                clk;
   logic                rst_n;
   dbg_pkg::dbg_flit_t  in_flit;
   logic                in_valid;
   logic                in_ready;
   dbg_pkg::dbg_flit_t  out_flit;
   logic                out_valid;
   logic                out_ready;
   dbg_pkg::trace_evt_t trace;
   logic                sys_clk_disable;
   logic                cpu_stall;
   logic                cpu_reset;
   logic                start_cpu;

   row_t               rows [$];
   trace_rec_t         trace_q [$];
   trace_rec_t         exp_q [$];
   rsp_rec_t           rsp_q [$];
   dbg_pkg::dbg_flit_t cur_pkt [$];

   int          errors      = 0;
   int          test_errors = 0;
   int          start_cnt   = 0;
   logic [15:0] cycle_cnt   = '0;
   logic [1:0]  ready_mode  = 2'd0;
   logic        trace_on    = 1'b0;

   debug_system i_debug_system (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_flit         (in_flit),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .out_flit        (out_flit),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .trace           (trace),
      .sys_clk_disable (sys_clk_disable),
      .cpu_stall       (cpu_stall),
      .cpu_reset       (cpu_reset),
      .start_cpu       (start_cpu)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_equal(input string what, input logic [47:0] got,
                              input logic [47:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   // Mode 0 always ready, 1 held low, 2 random gaps
   always @(posedge clk) begin
      case (ready_mode)
         2'd0:    out_ready <= 1'b1;
         2'd1:    out_ready <= 1'b0;
         default: out_ready <= (($urandom() % 4) != 0);
      endcase
   end

   // Cycles since reset, the reference for expected timestamps
   always @(posedge clk) begin
      cycle_cnt <= rst_n ? cycle_cnt + 1'b1 : '0;
      if (rst_n && start_cpu)
         start_cnt <= start_cnt + 1;
   end

   // Host side, collects whole packets and sorts them by class
   always @(posedge clk) begin : host_model
      dbg_pkg::dbg_flit_t   hf;
      dbg_pkg::dbg_header_t h;
      trace_rec_t           tr;
      rsp_rec_t             rr;
      if (rst_n && out_valid && out_ready) begin
         cur_pkt.push_back(out_flit);
         if (out_flit.ftype == dbg_pkg::FLIT_LAST || out_flit.ftype == dbg_pkg::FLIT_SINGLE) begin
            hf = cur_pkt[0];
            h  = hf.content.header;
            check_equal("first flit type", hf.ftype, dbg_pkg::FLIT_HEADER);
            if (h.pkt_class == dbg_pkg::CLASS_TRACE) begin
               check_equal("trace packet length", cur_pkt.size(), 4);
               check_equal("trace dest", h.dest, dbg_pkg::ADDR_EXT);
               check_equal("trace src", h.src, 8'(dbg_pkg::ADDR_ITM));
               if (cur_pkt.size() == 4) begin
                  check_equal("trace flit 1 type", cur_pkt[1].ftype, dbg_pkg::FLIT_PAYLOAD);
                  check_equal("trace flit 2 type", cur_pkt[2].ftype, dbg_pkg::FLIT_PAYLOAD);
                  tr.ts = cur_pkt[1].content.data;
                  tr.pc = {cur_pkt[2].content.data, cur_pkt[3].content.data};
                  trace_q.push_back(tr);
               end
            end else begin
               check_equal("response class", h.pkt_class, dbg_pkg::CLASS_REG);
               check_equal("response length", cur_pkt.size(), 2);
               rr.dest  = h.dest;
               rr.src   = h.src;
               rr.value = out_flit.content.data;
               rsp_q.push_back(rr);
            end
            cur_pkt.delete();
         end
      end
   end

   function automatic logic [15:0] make_header(input logic [4:0] dest, input logic [2:0] cls,
                                               input logic [7:0] src);
      dbg_pkg::dbg_header_t h;
      h.dest      = dest;
      h.pkt_class = cls;
      h.src       = src;
      return h;
   endfunction

   task automatic send_flit(input dbg_pkg::flit_type_e t, input logic [15:0] word);
      dbg_pkg::dbg_flit_t f;
      f.ftype        = t;
      f.content.data = word;
      in_flit  <= f;
      in_valid <= 1'b1;
      do @(posedge clk); while (!in_ready);
   endtask

   // Holds the event until the ITM accepts it
   task automatic send_event(input logic [31:0] pc);
      dbg_pkg::trace_evt_t e;
      trace_rec_t          r;
      e.valid = 1'b1;
      e.pc    = pc;
      trace <= e;
      do @(posedge clk); while (sys_clk_disable);
      if (trace_on) begin
         r.ts = cycle_cnt;
         r.pc = pc;
         exp_q.push_back(r);
      end
   endtask

   task automatic send_events(input int n);
      for (int k = 0; k < n; k++)
         send_event($urandom());
      trace <= '0;
   endtask

   task automatic wait_trace(input int n, input int limit);
      int c;
      c = 0;
      while (trace_q.size() < n && c < limit) begin
         @(negedge clk);
         c++;
      end
      if (trace_q.size() < n) begin
         $display("Timeout: only %0d of %0d trace packets arrived", trace_q.size(), n);
         errors++;
         test_errors++;
      end
   endtask

   task automatic compare_trace();
      check_equal("trace packet count", trace_q.size(), exp_q.size());
      for (int k = 0; k < trace_q.size() && k < exp_q.size(); k++) begin
         check_equal("trace pc", trace_q[k].pc, exp_q[k].pc);
         check_equal("trace timestamp", trace_q[k].ts, exp_q[k].ts);
         if (k > 0)
            check_equal("timestamp increases", trace_q[k].ts > trace_q[k-1].ts, 1'b1);
      end
   endtask

   task automatic do_read(input logic [14:0] addr, input logic [7:0] src,
                          input logic [15:0] exp);
      rsp_rec_t rr;
      int       c;
      send_flit(dbg_pkg::FLIT_HEADER, make_header(dbg_pkg::ADDR_TCM, dbg_pkg::CLASS_REG, src));
      send_flit(dbg_pkg::FLIT_LAST, {1'b0, addr});
      in_valid <= 1'b0;
      c = 0;
      while (rsp_q.size() == 0 && c < 200) begin
         @(negedge clk);
         c++;
      end
      if (rsp_q.size() == 0) begin
         $display("Timeout: no register response for address %0h", addr);
         errors++;
         test_errors++;
      end else begin
         rr = rsp_q.pop_front();
         check_equal("response dest", rr.dest, src[4:0]);
         check_equal("response src", rr.src, 8'(dbg_pkg::ADDR_TCM));
         check_equal("read value", rr.value, exp);
      end
   endtask

   task automatic do_write(input logic [14:0] addr, input logic [15:0] data, input int pulses);
      int base;
      send_flit(dbg_pkg::FLIT_HEADER, make_header(dbg_pkg::ADDR_TCM, dbg_pkg::CLASS_REG, 8'd3));
      send_flit(dbg_pkg::FLIT_PAYLOAD, {1'b1, addr});
      base = start_cnt;
      send_flit(dbg_pkg::FLIT_LAST, data);
      in_valid <= 1'b0;
      @(negedge clk);
      check_equal("cpu_stall", cpu_stall, data[dbg_pkg::CPU_CTRL_STALL_BIT]);
      check_equal("cpu_reset", cpu_reset, data[dbg_pkg::CPU_CTRL_RESET_BIT]);
      repeat (4) @(negedge clk);
      check_equal("start_cpu pulse cycles", start_cnt - base, pulses);
   endtask

   task automatic run_burst(input int n);
      logic seen;
      int   c;
      seen = 1'b0;
      ready_mode <= 2'd1;
      fork
         send_events(n);
         begin
            c = 0;
            while (!seen && c < 100) begin
               @(negedge clk);
               seen = sys_clk_disable;
               c++;
            end
            repeat (5) @(negedge clk);
            ready_mode <= 2'd0;
         end
      join
      check_equal("sys_clk_disable rose", seen, 1'b1);
      wait_trace(n, 40 * n);
      compare_trace();
      @(negedge clk);
      check_equal("sys_clk_disable after drain", sys_clk_disable, 1'b0);
   endtask

   initial begin
      int rnd;
      rnd       = $urandom(32'h5a57);
      rst_n     = 1'b0;
      in_flit   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      trace     = '0;

      rows.push_back({OP_READ, 16'(dbg_pkg::REG_SYSTEM_ID), 16'h0, dbg_pkg::SYSTEM_ID});
      rows.push_back({OP_READ, 16'(dbg_pkg::REG_MODULE_COUNT), 16'h0, dbg_pkg::MODULE_COUNT});
      rows.push_back({OP_READ, 16'h0009, 16'h0, 16'h0000});
      rows.push_back({OP_WRITE, 16'(dbg_pkg::REG_CPU_CTRL), 16'h0003, 16'h0000});
      rows.push_back({OP_READ, 16'(dbg_pkg::REG_CPU_CTRL), 16'h0, 16'h0003});
      rows.push_back({OP_WRITE, 16'(dbg_pkg::REG_CPU_CTRL), 16'h0004, 16'h0001});
      rows.push_back({OP_READ, 16'(dbg_pkg::REG_CPU_CTRL), 16'h0, 16'h0000});
      rows.push_back({OP_TRACE, 16'd3, 16'h0, 16'd0});
      rows.push_back({OP_CFG, 16'h0, 16'h0001, 16'h0});
      rows.push_back({OP_TRACE, 16'd5, 16'h0, 16'd5});
      rows.push_back({OP_BURST, 16'd7, 16'h0, 16'd7});
      rows.push_back({OP_DROP, 16'h0, 16'h0, 16'h0});
      rows.push_back({OP_MIXED, 16'd6, 16'(dbg_pkg::REG_SYSTEM_ID), dbg_pkg::SYSTEM_ID});
      rows.push_back({OP_CFG, 16'h0, 16'h0000, 16'h0});
      rows.push_back({OP_TRACE, 16'd2, 16'h0, 16'd0});

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         test_errors = 0;
         trace_q.delete();
         exp_q.delete();
         rsp_q.delete();
         case (rows[i].op)
            OP_READ:  do_read(rows[i].arg[14:0], 8'(4 + i), rows[i].exp);
            OP_WRITE: do_write(rows[i].arg[14:0], rows[i].data, rows[i].exp);
            OP_CFG: begin
               send_flit(dbg_pkg::FLIT_HEADER,
                         make_header(dbg_pkg::ADDR_ITM, dbg_pkg::CLASS_CONFIG, 8'd0));
               send_flit(dbg_pkg::FLIT_LAST, rows[i].data);
               in_valid <= 1'b0;
               trace_on = rows[i].data[0];
               repeat (2) @(posedge clk);
            end
            OP_TRACE: begin
               send_events(rows[i].arg);
               if (rows[i].exp == 0)
                  repeat (30) @(negedge clk);
               else
                  wait_trace(rows[i].exp, 40 * rows[i].exp);
               check_equal("trace packets", trace_q.size(), rows[i].exp);
               compare_trace();
            end
            OP_BURST: run_burst(rows[i].arg);
            OP_DROP: begin
               send_flit(dbg_pkg::FLIT_HEADER, make_header(5'd9, dbg_pkg::CLASS_REG, 8'd3));
               send_flit(dbg_pkg::FLIT_LAST, 16'h0000);
               in_valid <= 1'b0;
               repeat (30) @(negedge clk);
               check_equal("packets from dropped request", trace_q.size() + rsp_q.size(), 0);
            end
            default: begin
               ready_mode <= 2'd2;
               fork
                  send_events(rows[i].arg);
                  begin
                     repeat (3) @(posedge clk);
                     do_read(rows[i].data[14:0], 8'(4 + i), rows[i].exp);
                  end
               join
               wait_trace(rows[i].arg, 60 * rows[i].arg);
               compare_trace();
               ready_mode <= 2'd0;
            end
         endcase
         $display("Test %0d %s: %s", i, rows[i].op.name(),
                  (test_errors == 0) ? "passed" : "failed");
      end

      $display("Tests run %0d, failed checks %0d", rows.size(), errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Watchdog scaled by the number of table rows
   initial begin
      #1;
      #(rows.size() * 300 * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", rows.size() * 300);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- sources.f
design/dbg_pkg.sv
design/dbg_in_router.sv
design/tcm.sv
design/itm.sv
design/dbg_out_arbiter.sv
design/debug_system.sv
testbench/tb_debug_system.sv
